// ==== Makefile ====
# Verilator build for the CSR index engine testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= csr_index_tb
RTL_TOP   ?= csr_index_engine
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   ?= $(OBJ_DIR)/V$(TB_TOP)

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# Exit status of the simulation binary is the test result
sim: $(SIM_BIN)
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/csr_index_tb.sv ====
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_tb;

    import csr_index_mem_pkg::*;
    import csr_index_ctrl_pkg::*;

    localparam int NUM_RUNS = 3;

    // Phases of the done_o tracker
    localparam int PH_IDLE   = 0;
    localparam int PH_SETTLE = 1;
    localparam int PH_RUN    = 2;
    localparam int PH_HOLD   = 3;

    logic           ap_clk = 1'b0;
    logic           areset_csr_engine;
    descriptor_t    descriptor_i;
    mem_response_t  mem_response_i;
    logic           mem_credit_i;
    logic           engine_credit_i;
    mem_request_t   mem_request_o;
    engine_packet_t engine_packet_o;
    logic           done_o;

    integer seed = 22968;

    // Per-run configuration, drawn before reset
    logic [`CSR_ADDR_W-1:0] desc_base  [NUM_RUNS];
    logic [`CSR_ADDR_W-1:0] array_base [NUM_RUNS];
    logic [`CSR_CNT_W-1:0]  first_idx  [NUM_RUNS];
    logic [`CSR_CNT_W-1:0]  idx_count  [NUM_RUNS];
    int                     idle_gap   [NUM_RUNS];
    int                     run_idx = 0;

    // Reference model, expected requests and packets in order
    mem_request_t   req_q [$];
    engine_packet_t pkt_q [$];

    // Memory and consumer models
    mem_response_t  resp_q [$];
    int             due_q [$];
    int             last_due = 0;
    int             mem_credits = `CSR_MEM_CREDITS;
    int             mem_owed = 0;
    int             eng_credits = `CSR_ENG_CREDITS;
    int             eng_owed = 0;

    int             cycle_cnt = 0;
    int             cycle_limit = 0;
    int             phase = PH_IDLE;
    int             done_count = 0;

    csr_index_engine csr_index_engine_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .descriptor_i      (descriptor_i),
        .mem_response_i    (mem_response_i),
        .mem_credit_i      (mem_credit_i),
        .engine_credit_i   (engine_credit_i),
        .mem_request_o     (mem_request_o),
        .engine_packet_o   (engine_packet_o),
        .done_o            (done_o)
    );

    always #10 ap_clk = ~ap_clk;

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_request(input mem_request_t exp_req, input mem_request_t act_req);
        if (act_req !== exp_req) begin
            $display("Mismatch mem_request_o: expected %h, got %h", exp_req, act_req);
            abort_run();
        end
    endtask

    task automatic check_packet(input engine_packet_t exp_pkt, input engine_packet_t act_pkt);
        if (act_pkt !== exp_pkt) begin
            $display("Mismatch engine_packet_o: expected %h, got %h", exp_pkt, act_pkt);
            abort_run();
        end
    endtask

    task automatic check_done(input logic exp_done, input logic act_done);
        if (act_done !== exp_done) begin
            $display("Mismatch done_o: expected %h, got %h", exp_done, act_done);
            abort_run();
        end
    endtask

    // Configuration block of the current run, word order as in csr_config_t
    function automatic logic [`CSR_DATA_W-1:0] config_word(input logic [`CSR_ADDR_W-1:0] addr);
        logic [`CSR_DATA_W-1:0] word;
        word = '0;
        if (addr == desc_base[run_idx]) begin
            word = array_base[run_idx];
        end else if (addr == desc_base[run_idx] + 32'd4) begin
            word = 32'(first_idx[run_idx]);
        end else if (addr == desc_base[run_idx] + 32'd8) begin
            word = 32'(idx_count[run_idx]);
        end
        return word;
    endfunction

    task automatic load_expectations(input int r);
        mem_request_t   req;
        engine_packet_t pkt;
        for (int w = 0; w < `CSR_CFG_WORDS; w++) begin
            req.valid   = 1'b1;
            req.cmd     = CMD_READ_CONFIG;
            req.tag     = `CSR_TAG_W'(w);
            req.address = desc_base[r] + 32'(4 * w);
            req_q.push_back(req);
        end
        for (int k = 0; k < int'(idx_count[r]); k++) begin
            req.cmd     = CMD_READ_INDEX;
            req.tag     = `CSR_TAG_W'(k);
            req.address = array_base[r] + ((32'(first_idx[r]) + 32'(k)) * 4);
            req_q.push_back(req);
            pkt.valid   = 1'b1;
            pkt.index   = first_idx[r] + `CSR_CNT_W'(k);
            pkt.value   = req.address ^ 32'h5A5A_0000;
            pkt_q.push_back(pkt);
        end
    endtask

    // ----------------------------------------------------------------------
    // Memory, consumer and done models
    // ----------------------------------------------------------------------
    task automatic serve_memory(output mem_response_t resp_drive, output logic credit_drive);
        mem_response_t resp;
        int            due;
        if (mem_request_o.valid) begin
            if (req_q.size() == 0) begin
                $display("Unexpected memory request to address %h", mem_request_o.address);
                abort_run();
            end else begin
                check_request(req_q.pop_front(), mem_request_o);
                resp.valid = 1'b1;
                resp.cmd   = mem_request_o.cmd;
                resp.tag   = mem_request_o.tag;
                if (mem_request_o.cmd == CMD_READ_INDEX) begin
                    resp.data = mem_request_o.address ^ 32'h5A5A_0000;
                end else begin
                    resp.data = config_word(mem_request_o.address);
                end
                // Latency of 1 to 4 cycles, never overtaking an older response
                due = cycle_cnt + 1 + int'({$random(seed)} % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                resp_q.push_back(resp);
                due_q.push_back(due);
                mem_owed++;
                mem_credits--;
                if (mem_credits < 0) begin
                    $display("Memory request issued with no credit left");
                    abort_run();
                end
            end
        end
        resp_drive = '0;
        if ((resp_q.size() != 0) && (due_q[0] <= cycle_cnt)) begin
            resp_drive = resp_q.pop_front();
            due_q.delete(0);
        end
        credit_drive = 1'b0;
        if ((mem_owed != 0) && (({$random(seed)} % 3) != 0)) begin
            credit_drive = 1'b1;
            mem_owed--;
            mem_credits++;
        end
    endtask

    task automatic consume_packets(output logic credit_drive);
        if (engine_packet_o.valid) begin
            if (pkt_q.size() == 0) begin
                $display("Unexpected engine packet with index %h", engine_packet_o.index);
                abort_run();
            end else begin
                check_packet(pkt_q.pop_front(), engine_packet_o);
                eng_owed++;
                eng_credits--;
                if (eng_credits < 0) begin
                    $display("Engine packet sent with no credit left");
                    abort_run();
                end
            end
        end
        // Slower consumer so the engine credits run dry now and then
        credit_drive = 1'b0;
        if ((eng_owed != 0) && (({$random(seed)} % 2) == 0)) begin
            credit_drive = 1'b1;
            eng_owed--;
            eng_credits++;
        end
    endtask

    task automatic track_done(output logic done_seen);
        done_seen = 1'b0;
        if (descriptor_i.valid) begin
            // The old done level stays visible for two more samples
            phase = PH_SETTLE;
        end else begin
            case (phase)
                PH_SETTLE: phase = PH_RUN;
                PH_RUN: begin
                    if (done_o && (req_q.size() == 0) && (pkt_q.size() == 0)) begin
                        phase     = PH_HOLD;
                        done_seen = 1'b1;
                    end else begin
                        check_done(1'b0, done_o);
                    end
                end
                PH_HOLD: check_done(1'b1, done_o);
                default: check_done(1'b0, done_o);
            endcase
        end
    endtask

    always @(posedge ap_clk) begin
        mem_response_t resp_drive;
        logic          mem_credit_drive;
        logic          eng_credit_drive;
        logic          done_seen;
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the runs did not finish", cycle_cnt);
            abort_run();
        end else if (!areset_csr_engine) begin
            serve_memory(resp_drive, mem_credit_drive);
            consume_packets(eng_credit_drive);
            track_done(done_seen);
            mem_response_i  <= resp_drive;
            mem_credit_i    <= mem_credit_drive;
            engine_credit_i <= eng_credit_drive;
            if (done_seen) begin
                done_count <= done_count + 1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus sequence
    // ----------------------------------------------------------------------
    initial begin
        int total;
        areset_csr_engine = 1'b1;
        descriptor_i      = '0;
        mem_response_i    = '0;
        mem_credit_i      = 1'b0;
        engine_credit_i   = 1'b0;
        total             = 0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            desc_base[r]  = {$random(seed)} & 32'hFFFF_FFFC;
            array_base[r] = {$random(seed)} & 32'hFFFF_FFFC;
            first_idx[r]  = `CSR_CNT_W'({$random(seed)});
            idx_count[r]  = `CSR_CNT_W'(1 + ({$random(seed)} % 40));
            idle_gap[r]   = 2 + int'({$random(seed)} % 4);
            total         = total + int'(idx_count[r]);
        end
        cycle_limit = 200 * (total + 10);

        repeat (2) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;

        for (int r = 0; r < NUM_RUNS; r++) begin
            // done_o of the previous run must hold through the gap
            repeat (idle_gap[r]) @(posedge ap_clk);
            run_idx = r;
            load_expectations(r);
            descriptor_i.valid <= 1'b1;
            descriptor_i.base  <= desc_base[r];
            @(posedge ap_clk);
            descriptor_i.valid <= 1'b0;
            while (done_count <= r) begin
                @(posedge ap_clk);
            end
        end

        // done_o of the last run must hold a few more cycles
        repeat (4) @(posedge ap_clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== design/csr_index_config.sv ====
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_config (
    input  logic                               ap_clk,
    input  logic                               areset_csr_engine,
    input  logic                               clear_i,
    input  csr_index_mem_pkg::mem_response_t   mem_response_i,
    output csr_index_ctrl_pkg::csr_config_t    cfg_o,
    output logic                               cfg_ready_o
);

    import csr_index_mem_pkg::*;

    logic [`CSR_CFG_WORDS-1:0] word_seen;
    logic                      cfg_hit;

    assign cfg_hit = mem_response_i.valid && (mem_response_i.cmd == CMD_READ_CONFIG);

    // Received-word mask, one bit per configuration word
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine || clear_i) begin
            word_seen <= '0;
        end else if (cfg_hit) begin
            for (int i = 0; i < `CSR_CFG_WORDS; i++) begin
                if (mem_response_i.tag == `CSR_TAG_W'(i)) begin
                    word_seen[i] <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Record fields, selected by the tag
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_hit) begin
            case (mem_response_i.tag)
                `CSR_TAG_W'(0): cfg_o.array_base  <= mem_response_i.data;
                `CSR_TAG_W'(1): cfg_o.first_index <= mem_response_i.data[`CSR_CNT_W-1:0];
                `CSR_TAG_W'(2): cfg_o.index_count <= mem_response_i.data[`CSR_CNT_W-1:0];
                default: ;
            endcase
        end
    end

    assign cfg_ready_o = &word_seen;

    // Only tags issued by the request generator may come back
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        cfg_hit |-> (mem_response_i.tag < `CSR_CFG_WORDS));

endmodule

// ==== design/csr_index_control.sv ====
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_control (
    input  logic                              ap_clk,
    input  logic                              areset_csr_engine,
    input  csr_index_ctrl_pkg::descriptor_t   descriptor_i,
    input  logic                              cfg_ready_i,
    input  logic                              gen_finished_i,
    input  logic                              drained_i,
    output logic                              gen_start_o,
    output csr_index_mem_pkg::mem_cmd_e       gen_op_o,
    output logic [`CSR_ADDR_W-1:0]            desc_base_o,
    output logic                              done_o
);

    import csr_index_mem_pkg::*;
    import csr_index_ctrl_pkg::*;

    engine_state_e state;
    logic          desc_accept;

    // A new descriptor is taken only between runs
    assign desc_accept = descriptor_i.valid && ((state == ST_IDLE) || (state == ST_DONE));

    // ----------------------------------------------------------------------
    // State register and generator start pulses
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state       <= ST_IDLE;
            gen_start_o <= 1'b0;
            gen_op_o    <= CMD_READ_CONFIG;
        end else begin
            gen_start_o <= 1'b0;
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (desc_accept) begin
                        state       <= ST_CFG_REQ;
                        gen_start_o <= 1'b1;
                        gen_op_o    <= CMD_READ_CONFIG;
                    end
                end
                ST_CFG_REQ: begin
                    if (gen_finished_i) begin
                        state <= ST_CFG_WAIT;
                    end
                end
                ST_CFG_WAIT: begin
                    if (cfg_ready_i) begin
                        state       <= ST_GEN;
                        gen_start_o <= 1'b1;
                        gen_op_o    <= CMD_READ_INDEX;
                    end
                end
                ST_GEN: begin
                    if (gen_finished_i) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (drained_i) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Base address of the configuration block
    always_ff @(posedge ap_clk) begin
        if (desc_accept) begin
            desc_base_o <= descriptor_i.base;
        end
    end

    // Held until the next descriptor moves the machine out of DONE
    assign done_o = (state == ST_DONE);

    // The generator only finishes a walk that the FSM is waiting on
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        gen_finished_i |-> ((state == ST_CFG_REQ) || (state == ST_GEN)));

endmodule

// ==== design/csr_index_ctrl_pkg.sv ====
`include "csr_index_params.svh"

package csr_index_ctrl_pkg;

    // Kernel descriptor, points at the configuration block
    typedef struct packed {
        logic                   valid;
        logic [`CSR_ADDR_W-1:0] base;
    } descriptor_t;

    // Configuration record, field order matches the word number in memory
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] array_base;
        logic [`CSR_CNT_W-1:0]  first_index;
        logic [`CSR_CNT_W-1:0]  index_count;
    } csr_config_t;

    // ----------------------------------------------------------------------
    // Engine sequencing states
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_CFG_REQ  = 3'd1,
        ST_CFG_WAIT = 3'd2,
        ST_GEN      = 3'd3,
        ST_DRAIN    = 3'd4,
        ST_DONE     = 3'd5
    } engine_state_e;

endpackage

// ==== design/csr_index_engine.sv ====
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_engine (
    input  logic                               ap_clk,
    input  logic                               areset_csr_engine,
    input  csr_index_ctrl_pkg::descriptor_t    descriptor_i,
    input  csr_index_mem_pkg::mem_response_t   mem_response_i,
    input  logic                               mem_credit_i,
    input  logic                               engine_credit_i,
    output csr_index_mem_pkg::mem_request_t    mem_request_o,
    output csr_index_mem_pkg::engine_packet_t  engine_packet_o,
    output logic                               done_o
);

    import csr_index_mem_pkg::*;
    import csr_index_ctrl_pkg::*;

    descriptor_t            desc_q;
    mem_response_t          resp_q;
    logic                   gen_start;
    mem_cmd_e               gen_op;
    logic [`CSR_ADDR_W-1:0] desc_base;
    logic                   gen_finished;
    csr_config_t            cfg;
    logic                   cfg_ready;
    logic                   cfg_clear;
    logic                   slot_avail;
    logic                   drained;
    logic                   issue;

    // ----------------------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            desc_q.valid <= 1'b0;
            resp_q.valid <= 1'b0;
        end else begin
            desc_q.valid <= descriptor_i.valid;
            resp_q.valid <= mem_response_i.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_q.base <= descriptor_i.base;
        resp_q.cmd  <= mem_response_i.cmd;
        resp_q.tag  <= mem_response_i.tag;
        resp_q.data <= mem_response_i.data;
    end

    // Old record is dropped when a configuration fetch starts
    assign cfg_clear = gen_start && (gen_op == CMD_READ_CONFIG);

    csr_index_control csr_index_control_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .descriptor_i      (desc_q),
        .cfg_ready_i       (cfg_ready),
        .gen_finished_i    (gen_finished),
        .drained_i         (drained),
        .gen_start_o       (gen_start),
        .gen_op_o          (gen_op),
        .desc_base_o       (desc_base),
        .done_o            (done_o)
    );

    csr_index_config csr_index_config_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .clear_i           (cfg_clear),
        .mem_response_i    (resp_q),
        .cfg_o             (cfg),
        .cfg_ready_o       (cfg_ready)
    );

    csr_index_request_gen csr_index_request_gen_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .start_i           (gen_start),
        .op_i              (gen_op),
        .desc_base_i       (desc_base),
        .cfg_i             (cfg),
        .mem_credit_i      (mem_credit_i),
        .slot_avail_i      (slot_avail),
        .mem_request_o     (mem_request_o),
        .issue_o           (issue),
        .finished_o        (gen_finished)
    );

    csr_index_response_path csr_index_response_path_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .mem_response_i    (resp_q),
        .issue_i           (issue),
        .cfg_i             (cfg),
        .engine_credit_i   (engine_credit_i),
        .slot_avail_o      (slot_avail),
        .drained_o         (drained),
        .engine_packet_o   (engine_packet_o)
    );

endmodule

// ==== design/csr_index_mem_pkg.sv ====
`include "csr_index_params.svh"

package csr_index_mem_pkg;

    // ----------------------------------------------------------------------
    // Memory command kinds
    // ----------------------------------------------------------------------
    typedef enum logic {
        CMD_READ_CONFIG = 1'b0,
        CMD_READ_INDEX  = 1'b1
    } mem_cmd_e;

    // ----------------------------------------------------------------------
    // Memory request and response
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                   valid;
        mem_cmd_e               cmd;
        logic [`CSR_TAG_W-1:0]  tag;
        logic [`CSR_ADDR_W-1:0] address;
    } mem_request_t;

    // Command and tag are echoed back by the memory
    typedef struct packed {
        logic                   valid;
        mem_cmd_e               cmd;
        logic [`CSR_TAG_W-1:0]  tag;
        logic [`CSR_DATA_W-1:0] data;
    } mem_response_t;

    // ----------------------------------------------------------------------
    // Packet towards the next engine
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                   valid;
        logic [`CSR_CNT_W-1:0]  index;
        logic [`CSR_DATA_W-1:0] value;
    } engine_packet_t;

endpackage

// ==== design/csr_index_params.svh ====
`ifndef CSR_INDEX_PARAMS_SVH
`define CSR_INDEX_PARAMS_SVH

// Bus widths
`define CSR_ADDR_W 32
`define CSR_DATA_W 32
`define CSR_TAG_W 8

// Configuration block in memory: array base, first index, index count
`define CSR_CFG_WORDS 3

// Credits granted after reset
`define CSR_MEM_CREDITS 4
`define CSR_ENG_CREDITS 4

// Index response buffer
`define CSR_RESP_DEPTH 8

// Index counters and packet index field
`define CSR_CNT_W 16

`endif

// ==== design/csr_index_request_gen.sv ====
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_request_gen (
    input  logic                              ap_clk,
    input  logic                              areset_csr_engine,
    input  logic                              start_i,
    input  csr_index_mem_pkg::mem_cmd_e       op_i,
    input  logic [`CSR_ADDR_W-1:0]            desc_base_i,
    input  csr_index_ctrl_pkg::csr_config_t   cfg_i,
    input  logic                              mem_credit_i,
    input  logic                              slot_avail_i,
    output csr_index_mem_pkg::mem_request_t   mem_request_o,
    output logic                              issue_o,
    output logic                              finished_o
);

    import csr_index_mem_pkg::*;

    localparam int CNT_W = `CSR_CNT_W;
    localparam int ADDR_W = `CSR_ADDR_W;
    localparam int CRD_W = $clog2(`CSR_MEM_CREDITS + 1);

    mem_cmd_e          op_q;
    logic              busy;
    logic [CNT_W-1:0]  offset;
    logic [CNT_W-1:0]  limit;
    logic [CRD_W-1:0]  credits;
    logic              fire;
    logic [ADDR_W-1:0] word_num;
    logic [ADDR_W-1:0] next_addr;

    // Index reads also need a reserved response slot
    assign fire    = busy && (credits != '0) && ((op_q == CMD_READ_CONFIG) || slot_avail_i);
    assign issue_o = fire && (op_q == CMD_READ_INDEX);

    assign limit = (op_q == CMD_READ_CONFIG) ? CNT_W'(`CSR_CFG_WORDS) : cfg_i.index_count;

    always_comb begin
        if (op_q == CMD_READ_CONFIG) begin
            word_num  = ADDR_W'(offset);
            next_addr = desc_base_i + {word_num[ADDR_W-3:0], 2'b00};
        end else begin
            word_num  = ADDR_W'(cfg_i.first_index) + ADDR_W'(offset);
            next_addr = cfg_i.array_base + {word_num[ADDR_W-3:0], 2'b00};
        end
    end

    // ----------------------------------------------------------------------
    // Walk control
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            busy       <= 1'b0;
            finished_o <= 1'b0;
            op_q       <= CMD_READ_CONFIG;
            offset     <= '0;
        end else begin
            finished_o <= 1'b0;
            if (start_i) begin
                op_q   <= op_i;
                offset <= '0;
                // An empty index range finishes at once
                if ((op_i == CMD_READ_INDEX) && (cfg_i.index_count == '0)) begin
                    finished_o <= 1'b1;
                end else begin
                    busy <= 1'b1;
                end
            end else if (fire) begin
                offset <= offset + 1'b1;
                if (offset == limit - 1'b1) begin
                    busy       <= 1'b0;
                    finished_o <= 1'b1;
                end
            end
        end
    end

    // Memory credits, one spent per request and one back per credit cycle
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            credits <= CRD_W'(`CSR_MEM_CREDITS);
        end else if (fire && !mem_credit_i) begin
            credits <= credits - 1'b1;
        end else if (!fire && mem_credit_i) begin
            credits <= credits + 1'b1;
        end
    end

    // Registered request output
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            mem_request_o.valid <= 1'b0;
        end else begin
            mem_request_o.valid <= fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        mem_request_o.cmd     <= op_q;
        mem_request_o.tag     <= offset[`CSR_TAG_W-1:0];
        mem_request_o.address <= next_addr;
    end

    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        credits <= CRD_W'(`CSR_MEM_CREDITS));

endmodule

// ==== design/csr_index_response_path.sv ====
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_response_path (
    input  logic                               ap_clk,
    input  logic                               areset_csr_engine,
    input  csr_index_mem_pkg::mem_response_t   mem_response_i,
    input  logic                               issue_i,
    input  csr_index_ctrl_pkg::csr_config_t    cfg_i,
    input  logic                               engine_credit_i,
    output logic                               slot_avail_o,
    output logic                               drained_o,
    output csr_index_mem_pkg::engine_packet_t  engine_packet_o
);

    import csr_index_mem_pkg::*;

    localparam int DEPTH = `CSR_RESP_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`CSR_ENG_CREDITS + 1);

    logic [`CSR_DATA_W-1:0] fifo_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       fifo_cnt;
    logic [CNT_W-1:0]       reserved;
    logic [CRD_W-1:0]       credits;
    logic [`CSR_CNT_W-1:0]  seq;
    logic                   push;
    logic                   pop;

    // Configuration responses are taken by the config block
    assign push = mem_response_i.valid && (mem_response_i.cmd == CMD_READ_INDEX);
    assign pop  = (fifo_cnt != '0) && (credits != '0);

    // Reserved covers reads in flight and entries still buffered
    assign slot_avail_o = (reserved < CNT_W'(DEPTH));
    assign drained_o    = (reserved == '0);

    // ----------------------------------------------------------------------
    // Counters and pointers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            reserved <= '0;
            credits  <= CRD_W'(`CSR_ENG_CREDITS);
            seq      <= '0;
        end else begin
            wr_ptr   <= wr_ptr + PTR_W'(push);
            rd_ptr   <= rd_ptr + PTR_W'(pop);
            fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
            reserved <= reserved + CNT_W'(issue_i) - CNT_W'(pop);
            credits  <= credits + CRD_W'(engine_credit_i) - CRD_W'(pop);
            if (pop) begin
                // Wraps after the last index of the run
                seq <= (seq == cfg_i.index_count - 1'b1) ? '0 : seq + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= mem_response_i.data;
        end
    end

    // Registered packet output
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            engine_packet_o.valid <= 1'b0;
        end else begin
            engine_packet_o.valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        engine_packet_o.index <= cfg_i.first_index + seq;
        engine_packet_o.value <= fifo_mem[rd_ptr];
    end

    // Slot reservation must keep the buffer from overflowing
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        push |-> (fifo_cnt < CNT_W'(DEPTH)));

endmodule

// ==== verilog.f ====
+incdir+design
design/csr_index_mem_pkg.sv
design/csr_index_ctrl_pkg.sv
design/csr_index_control.sv
design/csr_index_config.sv
design/csr_index_request_gen.sv
design/csr_index_response_path.sv
design/csr_index_engine.sv
bench/csr_index_tb.sv
